// ==== edge_filter_top.sv ====
// Sobel edge filter top

`timescale 1ns/1ns

module edge_filter_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                in_sof,
    input  logic                in_eol,
    input  pixel_pkg::pixel_t   in_pixel,
    output logic                in_ready,
    input  logic                out_ready,
    output logic                out_valid,
    output logic                out_sof,
    output logic                out_eol,
    output pixel_pkg::pixel_t   out_pixel
);

    logic              advance;
    logic              stage2_full;
    frame_pkg::col_t   lb_col;
    logic              lb_we;
    pixel_pkg::pixel_t tap_up1;
    pixel_pkg::pixel_t tap_up2;
    pixel_pkg::pixel_t p00;
    pixel_pkg::pixel_t p01;
    pixel_pkg::pixel_t p02;
    pixel_pkg::pixel_t p10;
    pixel_pkg::pixel_t p11;
    pixel_pkg::pixel_t p12;
    pixel_pkg::pixel_t p20;
    pixel_pkg::pixel_t p21;
    pixel_pkg::pixel_t p22;
    logic              win_valid;
    logic              win_border;
    logic              win_sof;
    logic              win_eol;

    window_3x3 u_window (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_sof      (in_sof),
        .in_eol      (in_eol),
        .in_pixel    (in_pixel),
        .in_ready    (in_ready),
        .stage2_full (stage2_full),
        .out_ready   (out_ready),
        .advance     (advance),
        .lb_col      (lb_col),
        .lb_we       (lb_we),
        .tap_up1     (tap_up1),
        .tap_up2     (tap_up2),
        .win_p00     (p00),
        .win_p01     (p01),
        .win_p02     (p02),
        .win_p10     (p10),
        .win_p11     (p11),
        .win_p12     (p12),
        .win_p20     (p20),
        .win_p21     (p21),
        .win_p22     (p22),
        .win_valid   (win_valid),
        .win_border  (win_border),
        .win_sof     (win_sof),
        .win_eol     (win_eol)
    );

    // previous two lines at the current column
    line_buffer u_lines (
        .clk   (clk),
        .col   (lb_col),
        .we    (lb_we),
        .pixel (in_pixel),
        .up1   (tap_up1),
        .up2   (tap_up2)
    );

    sobel_core u_sobel (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .win_p00     (p00),
        .win_p01     (p01),
        .win_p02     (p02),
        .win_p10     (p10),
        .win_p11     (p11),
        .win_p12     (p12),
        .win_p20     (p20),
        .win_p21     (p21),
        .win_p22     (p22),
        .win_valid   (win_valid),
        .win_border  (win_border),
        .win_sof     (win_sof),
        .win_eol     (win_eol),
        .stage2_full (stage2_full),
        .out_valid   (out_valid),
        .out_sof     (out_sof),
        .out_eol     (out_eol),
        .out_pixel   (out_pixel)
    );

endmodule

// ==== edge_golden.hex ====
// columns: flags (2 = sof, 1 = eol), input pixel, expected output pixel
// two 8x6 frames in raster order, one pixel per line
// frame 1, vertical and horizontal step edges that saturate
20a00
00a00
00a00
00a00
0c800
0c800
0c800
1c800
00a00
00a00
00a00
00a00
0c800
0c800
0c800
1c800
00a00
00a00
00a00
00a00
0c8ff
0c8ff
0c800
1c800
0c800
0c800
0c8ff
0c8ff
0c8ff
0c8ff
0c800
1c800
0c800
0c800
0c8ff
0c8ff
0c8ff
0c8ff
0c800
1c800
0c800
0c800
0c800
0c800
0c800
0c800
0c800
1c800
// frame 2, flat field with one bright pixel and a weak step in row 3
23200
03200
03200
03200
03200
03200
03200
13200
05000
03200
03200
03200
03200
03200
03200
13200
03200
03200
0323a
03200
03200
03200
03200
13200
03200
03200
0323a
03200
03300
03302
03302
13302
03200
03200
03200
03200
03200
03200
03200
13200
03200
03200
03200
03200
03200
03202
03202
13202

// ==== edge_settings.svh ====
// Edge filter settings

`ifndef EDGE_SETTINGS_SVH
`define EDGE_SETTINGS_SVH

// pixels per video line
// kept small so that test frames stay readable
`define EDGE_LINE_WIDTH 8

// column counter width of at least one bit
`define EDGE_COL_BITS ((`EDGE_LINE_WIDTH > 1) ? $clog2(`EDGE_LINE_WIDTH) : 1)

// soft cut offset subtracted from the gradient magnitude
// magnitudes at or below this value come out as zero
`define EDGE_SOFT_CUT 2

// saturation level of the output pixel
`define EDGE_PIX_MAX 255

`endif

// ==== frame_pkg.sv ====
// Raster position types

`include "edge_settings.svh"

package frame_pkg;

    // column index within a line
    typedef logic [`EDGE_COL_BITS-1:0] col_t;

    // row index that saturates at 2
    // only rows 0, 1 and 2-or-more need to be told apart
    typedef logic [1:0] row_t;

endpackage

// ==== line_buffer.sv ====
// Two-line pixel delay

`timescale 1ns/1ns

`include "edge_settings.svh"

module line_buffer #(
    parameter int DEPTH = `EDGE_LINE_WIDTH
) (
    input  logic                clk,
    input  frame_pkg::col_t     col,
    input  logic                we,
    input  pixel_pkg::pixel_t   pixel,
    output pixel_pkg::pixel_t   up1,
    output pixel_pkg::pixel_t   up2
);

    // mem_up1 holds the previous line, mem_up2 the one before it
    pixel_pkg::pixel_t mem_up1 [DEPTH];
    pixel_pkg::pixel_t mem_up2 [DEPTH];

    // asynchronous read of both lines at the current column
    assign up1 = mem_up1[col];
    assign up2 = mem_up2[col];

    // read-before-write cascade
    // the old line-1 value moves down into line 2 as the new pixel lands
    always_ff @(posedge clk) begin
        if (we) begin
            mem_up1[col] <= pixel;
            mem_up2[col] <= mem_up1[col];
        end
    end

endmodule

// ==== pixel_pkg.sv ====
// Pixel value types

package pixel_pkg;

    // 8-bit unsigned grayscale sample
    typedef logic [7:0] pixel_t;

    // unsigned absolute gradient or gradient magnitude
    // one weighted sum is at most 4 * 255 = 1020
    // |gx| + |gy| is at most 2040 which still fits in 11 bits
    typedef logic [10:0] grad_t;

endpackage

// ==== sobel_core.sv ====
// Sobel gradient pipeline

`timescale 1ns/1ns

`include "edge_settings.svh"

module sobel_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  pixel_pkg::pixel_t   win_p00,
    input  pixel_pkg::pixel_t   win_p01,
    input  pixel_pkg::pixel_t   win_p02,
    input  pixel_pkg::pixel_t   win_p10,
    input  pixel_pkg::pixel_t   win_p11,
    input  pixel_pkg::pixel_t   win_p12,
    input  pixel_pkg::pixel_t   win_p20,
    input  pixel_pkg::pixel_t   win_p21,
    input  pixel_pkg::pixel_t   win_p22,
    input  logic                win_valid,
    input  logic                win_border,
    input  logic                win_sof,
    input  logic                win_eol,
    output logic                stage2_full,
    output logic                out_valid,
    output logic                out_sof,
    output logic                out_eol,
    output pixel_pkg::pixel_t   out_pixel
);

    localparam pixel_pkg::grad_t PIX_MAX  = pixel_pkg::grad_t'(`EDGE_PIX_MAX);
    localparam pixel_pkg::grad_t SOFT_CUT = pixel_pkg::grad_t'(`EDGE_SOFT_CUT);

    // a + 2b + c for one side of a kernel
    function automatic pixel_pkg::grad_t side_sum(
        input pixel_pkg::pixel_t a,
        input pixel_pkg::pixel_t b,
        input pixel_pkg::pixel_t c
    );
        return pixel_pkg::grad_t'(a) + (pixel_pkg::grad_t'(b) << 1) + pixel_pkg::grad_t'(c);
    endfunction

    function automatic pixel_pkg::grad_t abs_diff(
        input pixel_pkg::grad_t pos,
        input pixel_pkg::grad_t neg
    );
        return (pos >= neg) ? pos - neg : neg - pos;
    endfunction

    pixel_pkg::grad_t gx_abs;
    pixel_pkg::grad_t gy_abs;
    pixel_pkg::grad_t mag;
    pixel_pkg::pixel_t clamped;
    logic s1_valid;
    logic s1_border;
    logic s1_sof;
    logic s1_eol;

    // stage 1 takes gx from the right and left columns and gy from the top and bottom rows
    always_ff @(posedge clk) begin
        if (advance) begin
            gx_abs    <= abs_diff(side_sum(win_p02, win_p12, win_p22),
                                  side_sum(win_p00, win_p10, win_p20));
            gy_abs    <= abs_diff(side_sum(win_p00, win_p01, win_p02),
                                  side_sum(win_p20, win_p21, win_p22));
            s1_border <= win_border;
            s1_sof    <= win_sof;
            s1_eol    <= win_eol;
        end
    end

    // both magnitudes come from the same window
    assign mag = gx_abs + gy_abs;

    always_comb begin
        if (mag > PIX_MAX) begin
            clamped = pixel_pkg::pixel_t'(PIX_MAX);
        end else if (mag > SOFT_CUT) begin
            clamped = pixel_pkg::pixel_t'(mag - SOFT_CUT);
        end else begin
            clamped = '0;
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (advance) begin
            out_pixel <= s1_border ? '0 : clamped;
            out_sof   <= s1_sof;
            out_eol   <= s1_eol;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= win_valid;
            out_valid <= s1_valid;
        end
    end

    assign stage2_full = out_valid;

endmodule

// ==== tb_edge_filter.sv ====
// Edge filter testbench

`timescale 1ns/1ns

`include "edge_settings.svh"

module tb_edge_filter;

    localparam int FRAMES      = 2;
    localparam int ROWS        = 6;
    localparam int N_ENTRIES   = FRAMES * ROWS * `EDGE_LINE_WIDTH;
    // first line of frame 1 runs with no gaps and no back-pressure
    localparam int OPEN_LEN    = `EDGE_LINE_WIDTH;
    localparam int LATENCY     = 3;
    localparam int CYCLE_LIMIT = 4 * N_ENTRIES + 100;
    localparam logic [31:0] SEED = 32'h57dda065;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic              in_sof;
    logic              in_eol;
    pixel_pkg::pixel_t in_pixel;
    logic              in_ready;
    logic              out_ready;
    logic              out_valid;
    logic              out_sof;
    logic              out_eol;
    pixel_pkg::pixel_t out_pixel;

    // word layout is sof at bit 17, eol at bit 16, input pixel at 15:8, expected output at 7:0
    logic [19:0] golden [N_ENTRIES];

    int                cycle    = 0;
    int                sent     = 0;
    int                received = 0;
    int                drv_idx  = 0;
    int                accept_cycle [N_ENTRIES];
    logic              stall_seen = 1'b0;
    pixel_pkg::pixel_t held_pixel;
    logic              held_sof;
    logic              held_eol;
    string             tag;

    edge_filter_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sof    (in_sof),
        .in_eol    (in_eol),
        .in_pixel  (in_pixel),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_sof   (out_sof),
        .out_eol   (out_eol),
        .out_pixel (out_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_beat(input int idx);
        in_valid = 1'b1;
        in_sof   = golden[idx][17];
        in_eol   = golden[idx][16];
        in_pixel = golden[idx][15:8];
        drv_idx  = idx;
    endtask

    // idle cycle with junk on the data lines
    task automatic drive_idle();
        in_valid = 1'b0;
        in_sof   = 1'b0;
        in_eol   = 1'b0;
        in_pixel = pixel_pkg::pixel_t'($urandom);
    endtask

    // stimulus changes only on the falling edge
    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_sof    = 1'b0;
        in_eol    = 1'b0;
        in_pixel  = '0;
        out_ready = 1'b0;
        $readmemh("edge_golden.hex", golden);
        if ($isunknown(golden[N_ENTRIES-1])) begin
            $display("TESTBENCH FAILED");
            $display("golden data file edge_golden.hex is missing or too short");
            $fatal(1, "no stimulus");
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // empty pipeline takes input even with the output blocked
        check_value("in_ready after reset", 1, in_ready);
        forever begin
            if (received < OPEN_LEN) begin
                out_ready = 1'b1;
            end else begin
                out_ready = ($urandom % 4) != 0;
            end
            // a beat that was not taken stays on the bus
            if (!(in_valid && (drv_idx == sent))) begin
                if (sent >= N_ENTRIES) begin
                    drive_idle();
                end else if ((sent >= OPEN_LEN) && (($urandom % 4) == 0)) begin
                    drive_idle();
                end else begin
                    drive_beat(sent);
                end
            end
            @(negedge clk);
        end
    end

    // handshake monitor sampled on the rising edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst_n) begin
            if (in_valid && in_ready) begin
                accept_cycle[sent] = cycle;
                sent = sent + 1;
            end
            // stalled output must not move
            if (stall_seen) begin
                tag = $sformatf("hold beat %0d out_valid", received);
                check_value(tag, 1, out_valid);
                tag = $sformatf("hold beat %0d out_pixel", received);
                check_value(tag, held_pixel, out_pixel);
                tag = $sformatf("hold beat %0d flags", received);
                check_value(tag, {held_sof, held_eol}, {out_sof, out_eol});
            end
            if (out_valid && out_ready) begin
                tag = $sformatf("beat %0d out_pixel", received);
                check_value(tag, golden[received][7:0], out_pixel);
                tag = $sformatf("beat %0d out_sof", received);
                check_value(tag, golden[received][17], out_sof);
                tag = $sformatf("beat %0d out_eol", received);
                check_value(tag, golden[received][16], out_eol);
                if (received < OPEN_LEN) begin
                    tag = $sformatf("beat %0d latency", received);
                    check_value(tag, LATENCY, cycle - accept_cycle[received]);
                end
                received = received + 1;
            end
            stall_seen = out_valid && !out_ready;
            held_pixel = out_pixel;
            held_sof   = out_sof;
            held_eol   = out_eol;
        end
    end

    initial begin
        wait ((received == N_ENTRIES) || (cycle >= CYCLE_LIMIT));
        if (received == N_ENTRIES) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $display("timeout, outputs stopped arriving after %0d of %0d beats",
                     received, N_ENTRIES);
            $fatal(1, "timeout");
        end
    end

endmodule

// ==== vlog.f ====
+incdir+.
pixel_pkg.sv
frame_pkg.sv
line_buffer.sv
window_3x3.sv
sobel_core.sv
edge_filter_top.sv
tb_edge_filter.sv

// ==== window_3x3.sv ====
// 3x3 window and raster tracking

`timescale 1ns/1ns

`include "edge_settings.svh"

module window_3x3 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                in_sof,
    input  logic                in_eol,
    input  pixel_pkg::pixel_t   in_pixel,
    output logic                in_ready,
    input  logic                stage2_full,
    input  logic                out_ready,
    output logic                advance,
    output frame_pkg::col_t     lb_col,
    output logic                lb_we,
    input  pixel_pkg::pixel_t   tap_up1,
    input  pixel_pkg::pixel_t   tap_up2,
    output pixel_pkg::pixel_t   win_p00,
    output pixel_pkg::pixel_t   win_p01,
    output pixel_pkg::pixel_t   win_p02,
    output pixel_pkg::pixel_t   win_p10,
    output pixel_pkg::pixel_t   win_p11,
    output pixel_pkg::pixel_t   win_p12,
    output pixel_pkg::pixel_t   win_p20,
    output pixel_pkg::pixel_t   win_p21,
    output pixel_pkg::pixel_t   win_p22,
    output logic                win_valid,
    output logic                win_border,
    output logic                win_sof,
    output logic                win_eol
);

    localparam frame_pkg::col_t COL_LAST = frame_pkg::col_t'(`EDGE_LINE_WIDTH - 1);
    localparam frame_pkg::row_t ROW_SAT  = 2'd2;

    // position of the next expected pixel
    frame_pkg::col_t col_q;
    frame_pkg::row_t row_q;

    // position of the pixel on the input right now
    frame_pkg::col_t cur_col;
    frame_pkg::row_t cur_row;
    logic            accept;
    logic            line_end;

    // whole pipeline moves when the last stage can empty or is empty
    assign advance  = !stage2_full || out_ready;
    assign in_ready = advance;
    assign accept   = in_valid && advance;

    // start of frame forces the origin
    assign cur_col  = in_sof ? '0 : col_q;
    assign cur_row  = in_sof ? '0 : row_q;
    assign line_end = in_eol || (cur_col == COL_LAST);

    assign lb_col = cur_col;
    assign lb_we  = accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (accept) begin
            if (line_end) begin
                col_q <= '0;
                row_q <= (cur_row == ROW_SAT) ? ROW_SAT : cur_row + 2'd1;
            end else begin
                col_q <= cur_col + 1'b1;
                row_q <= cur_row;
            end
        end
    end

    // shift left and take the new right column from the line taps and the input
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_p00    <= '0;
            win_p01    <= '0;
            win_p02    <= '0;
            win_p10    <= '0;
            win_p11    <= '0;
            win_p12    <= '0;
            win_p20    <= '0;
            win_p21    <= '0;
            win_p22    <= '0;
            win_valid  <= 1'b0;
            win_border <= 1'b0;
            win_sof    <= 1'b0;
            win_eol    <= 1'b0;
        end else if (advance) begin
            // a gap on the input becomes a bubble
            win_valid <= in_valid;
            if (in_valid) begin
                win_p00    <= win_p01;
                win_p01    <= win_p02;
                win_p02    <= tap_up2;
                win_p10    <= win_p11;
                win_p11    <= win_p12;
                win_p12    <= tap_up1;
                win_p20    <= win_p21;
                win_p21    <= win_p22;
                win_p22    <= in_pixel;
                // window would reach above row 0 or left of column 0
                win_border <= (cur_row < 2'd2) || (cur_col < frame_pkg::col_t'(2));
                win_sof    <= in_sof;
                win_eol    <= in_eol;
            end
        end
    end

endmodule
